// File: include/amo_defs.svh
`ifndef AMO_DEFS_SVH
`define AMO_DEFS_SVH

// x-check on a signal, only in cycles where en is high
`define AMO_ASSERT_KNOWN(lbl, clk, rst_b, en, sig) \
  lbl: assert property (@(posedge clk) disable iff (!rst_b) (en) |-> !$isunknown(sig))

// exactly one bit set, only in cycles where en is high
`define AMO_ASSERT_ONEHOT(lbl, clk, rst_b, en, sig) \
  lbl: assert property (@(posedge clk) disable iff (!rst_b) (en) |-> $onehot(sig))

`endif

// File: verilog/amo_pkg.sv
package amo_pkg;

  //==============================
  // widths
  //==============================
  // data path width
  localparam int XLEN       = 64;
  // adder needs one extra bit for the compare carry
  localparam int ADDER_W    = XLEN + 1;
  localparam int AMO_FUNC_W = 5;
  localparam int AMO_SIZE_W = 2;

  //==============================
  // amo op codes
  //==============================
  localparam logic [AMO_FUNC_W-1:0] OP_SWAP = 5'd0;
  localparam logic [AMO_FUNC_W-1:0] OP_ADD  = 5'd1;
  localparam logic [AMO_FUNC_W-1:0] OP_AND  = 5'd2;
  localparam logic [AMO_FUNC_W-1:0] OP_OR   = 5'd3;
  localparam logic [AMO_FUNC_W-1:0] OP_XOR  = 5'd4;
  localparam logic [AMO_FUNC_W-1:0] OP_MAX  = 5'd5;
  localparam logic [AMO_FUNC_W-1:0] OP_MIN  = 5'd6;
  localparam logic [AMO_FUNC_W-1:0] OP_MAXU = 5'd7;
  localparam logic [AMO_FUNC_W-1:0] OP_MINU = 5'd8;

  // size codes, only word and doubleword are legal for amo
  localparam logic [AMO_SIZE_W-1:0] SIZE_WORD  = 2'b10;
  localparam logic [AMO_SIZE_W-1:0] SIZE_DWORD = 2'b11;

  // store buffer index width, at least one bit
  function automatic int idx_w(input int depth);
    int w;
    w = 1;
    while ((1 << w) < depth)
    begin
      w++;
    end
    return w;
  endfunction

endpackage

// File: verilog/amo_req_stage.sv
`timescale 1ns/1ps
`include "amo_defs.svh"

module amo_req_stage #(
  parameter int STB_DEPTH = 4
) (
  input  logic                                 amo_clk,
  input  logic                                 cpurst_b,
  input  logic                                 req_vld,
  input  logic [amo_pkg::AMO_FUNC_W-1:0]       req_func,
  input  logic [amo_pkg::AMO_SIZE_W-1:0]       req_size,
  input  logic [amo_pkg::XLEN-1:0]             req_ld_data,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] req_id,
  output logic                                 da_vld,
  output logic [amo_pkg::AMO_FUNC_W-1:0]       da_func,
  output logic [amo_pkg::AMO_SIZE_W-1:0]       da_size,
  output logic [amo_pkg::XLEN-1:0]             da_src0,
  output logic [amo_pkg::idx_w(STB_DEPTH)-1:0] da_id
);

  //==============================
  // da stage valid
  //==============================
  // one cycle request pipe
  always_ff @(posedge amo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      da_vld <= 1'b0;
    end
    else
    begin
      da_vld <= req_vld;
    end
  end

  //==============================
  // da stage payload
  //==============================
  // fields only move on a new request
  always_ff @(posedge amo_clk)
  begin
    if (req_vld)
    begin
      da_func <= req_func;
      da_size <= req_size;
      // memory value from the load side
      da_src0 <= req_ld_data;
      da_id   <= req_id;
    end
  end

  //==============================
  // checks
  //==============================
  // issued request carries a legal op and size into da
  a_req_legal: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    req_vld |=> (da_func <= amo_pkg::OP_MINU) &&
                ((da_size == amo_pkg::SIZE_WORD) || (da_size == amo_pkg::SIZE_DWORD)));

  // no x on the fields the alu decodes
  `AMO_ASSERT_KNOWN(a_da_known, amo_clk, cpurst_b, da_vld, {da_func, da_size, da_id});

endmodule

// File: verilog/amo_alu.sv
`timescale 1ns/1ps
`include "amo_defs.svh"

module amo_alu #(
  parameter int STB_DEPTH = 4
) (
  input  logic                                 amo_clk,
  input  logic                                 cpurst_b,
  input  logic                                 da_vld,
  input  logic [amo_pkg::AMO_FUNC_W-1:0]       da_func,
  input  logic [amo_pkg::AMO_SIZE_W-1:0]       da_size,
  input  logic [amo_pkg::XLEN-1:0]             da_src0,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] da_id,
  input  logic [amo_pkg::XLEN-1:0]             stb_src1,
  output logic                                 amo_rst_vld,
  output logic [amo_pkg::idx_w(STB_DEPTH)-1:0] amo_rst_id,
  output logic [amo_pkg::XLEN-1:0]             amo_rst_data
);

  localparam int XW = amo_pkg::XLEN;
  localparam int AW = amo_pkg::ADDER_W;

  // op decode
  logic          op_swap;
  logic          op_add;
  logic          op_and;
  logic          op_or;
  logic          op_xor;
  logic          op_max;
  logic          op_min;
  logic          op_maxu;
  logic          op_minu;
  // size and extension
  logic          sz_wd;
  logic          sz_dw;
  logic          ext_unsign;
  logic [3:0]    ext_sel;
  // adder path
  logic          adder_sel;
  logic          adder_sub;
  logic [XW-1:0] adder_src0;
  logic [XW-1:0] adder_src1;
  logic [AW-1:0] adder_rs0;
  logic [AW-1:0] adder_rs1_raw;
  logic [AW-1:0] adder_rs1;
  logic [AW-1:0] adder_sum;
  logic          adder_lt;
  // min/max/swap pick
  logic          src0_pick;
  logic [XW-1:0] pick_rst;
  // logic path
  logic          logic_sel;
  logic [XW-1:0] logic_src0;
  logic [XW-1:0] logic_src1;
  logic [XW-1:0] logic_rst;
  // result mux
  logic [2:0]    rst_sel;
  logic [XW-1:0] alu_rst;

  // sign or zero extend to adder width
  // sel is {dw_sign, dw_unsign, wd_sign, wd_unsign}
  function automatic logic [AW-1:0] ext_op(input logic [3:0] sel, input logic [XW-1:0] d);
    logic [AW-1:0] r;
    case (sel)
      4'b1000: r = {d[XW-1], d};
      4'b0100: r = {1'b0, d};
      4'b0010: r = {{(AW-32){d[31]}}, d[31:0]};
      4'b0001: r = {{(AW-32){1'b0}}, d[31:0]};
      default: r = '0;
    endcase
    return r;
  endfunction

  //==============================
  // decode
  //==============================
  assign op_swap = (da_func == amo_pkg::OP_SWAP);
  assign op_add  = (da_func == amo_pkg::OP_ADD);
  assign op_and  = (da_func == amo_pkg::OP_AND);
  assign op_or   = (da_func == amo_pkg::OP_OR);
  assign op_xor  = (da_func == amo_pkg::OP_XOR);
  assign op_max  = (da_func == amo_pkg::OP_MAX);
  assign op_min  = (da_func == amo_pkg::OP_MIN);
  assign op_maxu = (da_func == amo_pkg::OP_MAXU);
  assign op_minu = (da_func == amo_pkg::OP_MINU);

  assign sz_wd = (da_size == amo_pkg::SIZE_WORD);
  assign sz_dw = (da_size == amo_pkg::SIZE_DWORD);

  // only the unsigned compares zero extend
  assign ext_unsign = op_maxu | op_minu;
  assign ext_sel    = {sz_dw & ~ext_unsign, sz_dw & ext_unsign,
                       sz_wd & ~ext_unsign, sz_wd & ext_unsign};

  //==============================
  // adder
  //==============================
  // add and all compares share one adder
  assign adder_sel = op_add | op_max | op_min | op_maxu | op_minu;
  // everything but add is a subtract
  assign adder_sub = ~op_add;

  // idle operands held at zero to keep the adder quiet
  assign adder_src0 = {XW{adder_sel}} & da_src0;
  assign adder_src1 = {XW{adder_sel}} & stb_src1;

  assign adder_rs0     = ext_op(ext_sel, adder_src0);
  assign adder_rs1_raw = ext_op(ext_sel, adder_src1);
  // invert plus carry in for subtract
  assign adder_rs1 = adder_sub ? ~adder_rs1_raw : adder_rs1_raw;
  assign adder_sum = adder_rs0 + adder_rs1 + {{(AW-1){1'b0}}, adder_sub};

  // top bit of the extended difference, set when src0 < src1
  assign adder_lt = adder_sum[AW-1];

  //==============================
  // min / max / swap
  //==============================
  // max keeps src0 when not less, min keeps src0 when less
  // swap always returns the register operand
  assign src0_pick = ((op_max | op_maxu) ^ adder_lt) & ~op_swap;
  assign pick_rst  = src0_pick ? da_src0 : stb_src1;

  //==============================
  // logic ops
  //==============================
  assign logic_sel  = op_and | op_or | op_xor;
  assign logic_src0 = {XW{logic_sel}} & da_src0;
  assign logic_src1 = {XW{logic_sel}} & stb_src1;

  assign logic_rst = ({XW{op_and}} & (logic_src0 & logic_src1)) |
                     ({XW{op_or}}  & (logic_src0 | logic_src1)) |
                     ({XW{op_xor}} & (logic_src0 ^ logic_src1));

  //==============================
  // result select
  //==============================
  // {pick, logic, adder}
  assign rst_sel = {op_swap | op_max | op_min | op_maxu | op_minu, logic_sel, op_add};

  always_comb
  begin
    case (rst_sel)
      3'b001:  alu_rst = adder_sum[XW-1:0];
      3'b010:  alu_rst = logic_rst;
      3'b100:  alu_rst = pick_rst;
      default: alu_rst = '0;
    endcase
  end

  //==============================
  // result flop
  //==============================
  always_ff @(posedge amo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      amo_rst_vld <= 1'b0;
    end
    else
    begin
      amo_rst_vld <= da_vld;
    end
  end

  // result and index follow the valid one cycle later
  always_ff @(posedge amo_clk)
  begin
    if (da_vld)
    begin
      amo_rst_data <= alu_rst;
      amo_rst_id   <= da_id;
    end
  end

  // every issued op lands on exactly one result source
  `AMO_ASSERT_ONEHOT(a_rst_sel_onehot, amo_clk, cpurst_b, da_vld, rst_sel);

endmodule

// File: verilog/amo_stb.sv
`timescale 1ns/1ps
`include "amo_defs.svh"

module amo_stb #(
  parameter int STB_DEPTH = 4
) (
  input  logic                                 amo_clk,
  input  logic                                 cpurst_b,
  input  logic                                 alloc_vld,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] alloc_id,
  input  logic [amo_pkg::XLEN-1:0]             alloc_data,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] da_id,
  input  logic                                 amo_rst_vld,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] amo_rst_id,
  input  logic [amo_pkg::XLEN-1:0]             amo_rst_data,
  input  logic                                 mem_stall,
  output logic [amo_pkg::XLEN-1:0]             stb_src1,
  output logic                                 mem_wr_vld,
  output logic [amo_pkg::idx_w(STB_DEPTH)-1:0] mem_wr_id,
  output logic [amo_pkg::XLEN-1:0]             mem_wr_data
);

  localparam int ID_W = amo_pkg::idx_w(STB_DEPTH);

  // entry state encoding
  localparam logic [1:0] ST_FREE = 2'b00;
  localparam logic [1:0] ST_PEND = 2'b01;
  localparam logic [1:0] ST_DONE = 2'b10;

  logic [1:0]              ent_st   [STB_DEPTH];
  logic [amo_pkg::XLEN-1:0] ent_data [STB_DEPTH];

  // drain pick
  logic                     pick_vld;
  logic [ID_W-1:0]          pick_id;
  logic                     pick_go;
  // drain stage ahead of the write port
  logic                     drn_vld;
  logic [ID_W-1:0]          drn_id;
  logic [amo_pkg::XLEN-1:0] drn_data;

  //==============================
  // operand read
  //==============================
  // register operand for the op in da
  assign stb_src1 = ent_data[da_id];

  //==============================
  // entry state
  //==============================
  // alloc, write-back and drain never touch the same entry
  always_ff @(posedge amo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int i = 0; i < STB_DEPTH; i++)
      begin
        ent_st[i] <= ST_FREE;
      end
    end
    else
    begin
      if (alloc_vld)
      begin
        ent_st[alloc_id] <= ST_PEND;
      end
      if (amo_rst_vld)
      begin
        ent_st[amo_rst_id] <= ST_DONE;
      end
      if (pick_go)
      begin
        ent_st[pick_id] <= ST_FREE;
      end
    end
  end

  // entry data, operand on alloc, result on write-back
  always_ff @(posedge amo_clk)
  begin
    if (alloc_vld)
    begin
      ent_data[alloc_id] <= alloc_data;
    end
    if (amo_rst_vld)
    begin
      ent_data[amo_rst_id] <= amo_rst_data;
    end
  end

  //==============================
  // drain
  //==============================
  // fixed priority, lowest done index wins
  always_comb
  begin
    pick_vld = 1'b0;
    pick_id  = '0;
    for (int i = STB_DEPTH - 1; i >= 0; i--)
    begin
      if (ent_st[i] == ST_DONE)
      begin
        pick_vld = 1'b1;
        pick_id  = ID_W'(i);
      end
    end
  end

  // stall freezes both the pick and the drain stage
  assign pick_go = pick_vld & ~mem_stall;

  always_ff @(posedge amo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      drn_vld    <= 1'b0;
      mem_wr_vld <= 1'b0;
    end
    else
    begin
      if (!mem_stall)
      begin
        drn_vld <= pick_vld;
      end
      mem_wr_vld <= drn_vld & ~mem_stall;
    end
  end

  always_ff @(posedge amo_clk)
  begin
    if (pick_go)
    begin
      drn_id   <= pick_id;
      drn_data <= ent_data[pick_id];
    end
    // memory write port
    if (drn_vld && !mem_stall)
    begin
      mem_wr_id   <= drn_id;
      mem_wr_data <= drn_data;
    end
  end

  //==============================
  // checks
  //==============================
  // alu result must come back to an entry still waiting for it
  a_wb_pending: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    amo_rst_vld |-> (ent_st[amo_rst_id] == ST_PEND));

  // no allocation over a live entry
  a_alloc_free: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    alloc_vld |-> (ent_st[alloc_id] == ST_FREE));

  `AMO_ASSERT_KNOWN(a_wb_id_known, amo_clk, cpurst_b, amo_rst_vld, amo_rst_id);

endmodule

// File: verilog/amo_lsu_top.sv
`timescale 1ns/1ps

module amo_lsu_top #(
  parameter int STB_DEPTH = 4
) (
  input  logic                                 amo_clk,
  input  logic                                 cpurst_b,
  // entry allocation
  input  logic                                 alloc_vld,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] alloc_id,
  input  logic [amo_pkg::XLEN-1:0]             alloc_data,
  // amo request
  input  logic                                 req_vld,
  input  logic [amo_pkg::AMO_FUNC_W-1:0]       req_func,
  input  logic [amo_pkg::AMO_SIZE_W-1:0]       req_size,
  input  logic [amo_pkg::XLEN-1:0]             req_ld_data,
  input  logic [amo_pkg::idx_w(STB_DEPTH)-1:0] req_id,
  // memory write side
  input  logic                                 mem_stall,
  output logic                                 mem_wr_vld,
  output logic [amo_pkg::idx_w(STB_DEPTH)-1:0] mem_wr_id,
  output logic [amo_pkg::XLEN-1:0]             mem_wr_data
);

  localparam int ID_W = amo_pkg::idx_w(STB_DEPTH);

  // da stage
  logic                           da_vld;
  logic [amo_pkg::AMO_FUNC_W-1:0] da_func;
  logic [amo_pkg::AMO_SIZE_W-1:0] da_size;
  logic [amo_pkg::XLEN-1:0]       da_src0;
  logic [ID_W-1:0]                da_id;
  // stb operand and alu result
  logic [amo_pkg::XLEN-1:0]       stb_src1;
  logic                           amo_rst_vld;
  logic [ID_W-1:0]                amo_rst_id;
  logic [amo_pkg::XLEN-1:0]       amo_rst_data;

  //==============================
  // request stage
  //==============================
  amo_req_stage #(.STB_DEPTH(STB_DEPTH)) u_req_stage (
    .amo_clk     (amo_clk),
    .cpurst_b    (cpurst_b),
    .req_vld     (req_vld),
    .req_func    (req_func),
    .req_size    (req_size),
    .req_ld_data (req_ld_data),
    .req_id      (req_id),
    .da_vld      (da_vld),
    .da_func     (da_func),
    .da_size     (da_size),
    .da_src0     (da_src0),
    .da_id       (da_id)
  );

  //==============================
  // alu
  //==============================
  amo_alu #(.STB_DEPTH(STB_DEPTH)) u_alu (
    .amo_clk      (amo_clk),
    .cpurst_b     (cpurst_b),
    .da_vld       (da_vld),
    .da_func      (da_func),
    .da_size      (da_size),
    .da_src0      (da_src0),
    .da_id        (da_id),
    .stb_src1     (stb_src1),
    .amo_rst_vld  (amo_rst_vld),
    .amo_rst_id   (amo_rst_id),
    .amo_rst_data (amo_rst_data)
  );

  //==============================
  // store buffer
  //==============================
  amo_stb #(.STB_DEPTH(STB_DEPTH)) u_stb (
    .amo_clk      (amo_clk),
    .cpurst_b     (cpurst_b),
    .alloc_vld    (alloc_vld),
    .alloc_id     (alloc_id),
    .alloc_data   (alloc_data),
    .da_id        (da_id),
    .amo_rst_vld  (amo_rst_vld),
    .amo_rst_id   (amo_rst_id),
    .amo_rst_data (amo_rst_data),
    .mem_stall    (mem_stall),
    .stb_src1     (stb_src1),
    .mem_wr_vld   (mem_wr_vld),
    .mem_wr_id    (mem_wr_id),
    .mem_wr_data  (mem_wr_data)
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 20,
  parameter int RST_CYCLES  = 10
) (
  output logic amo_clk,
  output logic cpurst_b
);

  // free running clock, 40 ns period
  initial
  begin
    amo_clk = 1'b0;
    forever
    begin
      #(HALF_PERIOD);
      amo_clk = ~amo_clk;
    end
  end

  // real falling edge on reset, then held for RST_CYCLES clocks
  initial
  begin
    cpurst_b = 1'b1;
    #1;
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge amo_clk);
    cpurst_b <= 1'b1;
  end

endmodule

// File: test/tb_amo_lsu.sv
`timescale 1ns/1ps

module tb_amo_lsu;

  localparam int STB_DEPTH   = 4;
  localparam int ID_W        = amo_pkg::idx_w(STB_DEPTH);
  // 8 add/swap, 6 logic, 16 min/max, 5 word, 4 stalled
  localparam int N_TRANS     = 39;
  localparam int TIMEOUT_CYC = 40 * N_TRANS + 200;

  logic                           amo_clk;
  logic                           cpurst_b;
  logic                           alloc_vld;
  logic [ID_W-1:0]                alloc_id;
  logic [amo_pkg::XLEN-1:0]       alloc_data;
  logic                           req_vld;
  logic [amo_pkg::AMO_FUNC_W-1:0] req_func;
  logic [amo_pkg::AMO_SIZE_W-1:0] req_size;
  logic [amo_pkg::XLEN-1:0]       req_ld_data;
  logic [ID_W-1:0]                req_id;
  logic                           mem_stall;
  logic                           mem_wr_vld;
  logic [ID_W-1:0]                mem_wr_id;
  logic [amo_pkg::XLEN-1:0]       mem_wr_data;

  // scoreboard keyed by entry index
  logic [amo_pkg::XLEN-1:0] sb_data [STB_DEPTH];
  logic [amo_pkg::XLEN-1:0] sb_mask [STB_DEPTH];
  // expected drain order
  logic [ID_W-1:0]          exp_ids [64];
  int                       wr_ptr = 0;
  int                       rd_ptr = 0;
  logic [amo_pkg::XLEN-1:0] exp_data;
  logic [amo_pkg::XLEN-1:0] exp_mask;
  logic [ID_W-1:0]          exp_id;

  // run control
  integer seed;
  logic   lat_mode;
  logic   req_seen;
  int     wb_cnt    = 0;
  int     cycle_cnt = 0;

  // error counters
  int value_err = 0;
  int order_err = 0;
  int lat_err   = 0;
  int stall_err = 0;
  int reset_err = 0;
  int drain_err = 0;

  tb_clk_gen u_clk_gen (
    .amo_clk  (amo_clk),
    .cpurst_b (cpurst_b)
  );

  amo_lsu_top #(.STB_DEPTH(STB_DEPTH)) u_dut (
    .amo_clk     (amo_clk),
    .cpurst_b    (cpurst_b),
    .alloc_vld   (alloc_vld),
    .alloc_id    (alloc_id),
    .alloc_data  (alloc_data),
    .req_vld     (req_vld),
    .req_func    (req_func),
    .req_size    (req_size),
    .req_ld_data (req_ld_data),
    .req_id      (req_id),
    .mem_stall   (mem_stall),
    .mem_wr_vld  (mem_wr_vld),
    .mem_wr_id   (mem_wr_id),
    .mem_wr_data (mem_wr_data)
  );

  //==============================
  // reference model
  //==============================
  // src0 is the memory value, src1 the register operand
  function automatic logic [63:0] ref_result(input logic [4:0] func, input logic [1:0] size,
                                             input logic [63:0] mem_v, input logic [63:0] reg_v);
    logic [63:0] a_s;
    logic [63:0] b_s;
    logic [63:0] a_u;
    logic [63:0] b_u;
    logic [63:0] r;
    // word compares look at the low half only
    if (size == amo_pkg::SIZE_WORD)
    begin
      a_s = {{32{mem_v[31]}}, mem_v[31:0]};
      b_s = {{32{reg_v[31]}}, reg_v[31:0]};
      a_u = {32'd0, mem_v[31:0]};
      b_u = {32'd0, reg_v[31:0]};
    end
    else
    begin
      a_s = mem_v;
      b_s = reg_v;
      a_u = mem_v;
      b_u = reg_v;
    end
    case (func)
      amo_pkg::OP_SWAP: r = reg_v;
      amo_pkg::OP_ADD:  r = mem_v + reg_v;
      amo_pkg::OP_AND:  r = mem_v & reg_v;
      amo_pkg::OP_OR:   r = mem_v | reg_v;
      amo_pkg::OP_XOR:  r = mem_v ^ reg_v;
      amo_pkg::OP_MAX:  r = ($signed(a_s) >= $signed(b_s)) ? mem_v : reg_v;
      amo_pkg::OP_MIN:  r = ($signed(a_s) < $signed(b_s)) ? mem_v : reg_v;
      amo_pkg::OP_MAXU: r = (a_u >= b_u) ? mem_v : reg_v;
      amo_pkg::OP_MINU: r = (a_u < b_u) ? mem_v : reg_v;
      default:          r = 'x;
    endcase
    return r;
  endfunction

  function automatic logic [63:0] rand_dword();
    logic [63:0] d;
    d = {$random(seed), $random(seed)};
    return d;
  endfunction

  function automatic int err_total();
    return value_err + order_err + lat_err + stall_err + reset_err + drain_err;
  endfunction

  //==============================
  // stimulus tasks
  //==============================
  task automatic alloc_entry(input int id, input logic [63:0] data);
    @(posedge amo_clk);
    alloc_vld  <= 1'b1;
    alloc_id   <= ID_W'(id);
    alloc_data <= data;
    @(posedge amo_clk);
    alloc_vld  <= 1'b0;
  endtask

  // scoreboard entry plus its slot in the drain order
  task automatic expect_result(input int id, input logic [4:0] func, input logic [1:0] size,
                               input logic [63:0] mem_v, input logic [63:0] reg_v);
    sb_data[id] = ref_result(func, size, mem_v, reg_v);
    sb_mask[id] = (size == amo_pkg::SIZE_WORD) ? 64'h0000_0000_ffff_ffff : '1;
    exp_ids[wr_ptr] = ID_W'(id);
    wr_ptr = wr_ptr + 1;
  endtask

  task automatic issue_amo(input int id, input logic [4:0] func, input logic [1:0] size,
                           input logic [63:0] mem_v, input logic lat);
    @(posedge amo_clk);
    req_vld     <= 1'b1;
    req_func    <= func;
    req_size    <= size;
    req_ld_data <= mem_v;
    req_id      <= ID_W'(id);
    lat_mode    <= lat;
    req_seen    <= 1'b1;
  endtask

  task automatic end_req();
    @(posedge amo_clk);
    req_vld  <= 1'b0;
    lat_mode <= 1'b0;
  endtask

  // wait until every expected write has left
  task automatic wait_drained();
    while (rd_ptr != wr_ptr)
    begin
      @(posedge amo_clk);
    end
    @(posedge amo_clk);
  endtask

  // one amo with nothing else in flight
  task automatic run_single(input int id, input logic [4:0] func, input logic [1:0] size);
    logic [63:0] reg_v;
    logic [63:0] mem_v;
    reg_v = rand_dword();
    mem_v = rand_dword();
    alloc_entry(id, reg_v);
    repeat (2) @(posedge amo_clk);
    expect_result(id, func, size, mem_v, reg_v);
    issue_amo(id, func, size, mem_v, 1'b1);
    end_req();
    wait_drained();
  endtask

  // fill all entries under stall, issue out of order, then release
  task automatic run_stall_drain();
    logic [63:0] reg_v [4];
    logic [63:0] mem_v [4];
    logic [4:0]  func  [4];
    int          order [4];
    int          wb_goal;
    func  = '{amo_pkg::OP_ADD, amo_pkg::OP_XOR, amo_pkg::OP_MAXU, amo_pkg::OP_MIN};
    order = '{3, 1, 0, 2};
    @(posedge amo_clk);
    mem_stall <= 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      reg_v[i] = rand_dword();
      mem_v[i] = rand_dword();
      alloc_entry(i, reg_v[i]);
    end
    // drain goes lowest index first
    for (int i = 0; i < 4; i++)
    begin
      expect_result(i, func[i], amo_pkg::SIZE_DWORD, mem_v[i], reg_v[i]);
    end
    wb_goal = wb_cnt + 4;
    for (int k = 0; k < 4; k++)
    begin
      issue_amo(order[k], func[order[k]], amo_pkg::SIZE_DWORD, mem_v[order[k]], 1'b0);
    end
    end_req();
    while (wb_cnt < wb_goal)
    begin
      @(posedge amo_clk);
    end
    // done entries sit while stalled
    repeat (3) @(posedge amo_clk);
    mem_stall <= 1'b0;
    wait_drained();
  endtask

  task automatic print_counts();
    $display("errors value=%0d order=%0d latency=%0d stall=%0d reset=%0d drain=%0d",
             value_err, order_err, lat_err, stall_err, reset_err, drain_err);
  endtask

  //==============================
  // bookkeeping
  //==============================
  assign exp_data = sb_data[mem_wr_id];
  assign exp_mask = sb_mask[mem_wr_id];
  assign exp_id   = exp_ids[rd_ptr];

  always @(posedge amo_clk)
  begin
    if (mem_wr_vld)
    begin
      rd_ptr <= rd_ptr + 1;
    end
    if (u_dut.amo_rst_vld)
    begin
      wb_cnt <= wb_cnt + 1;
    end
  end

  // run limit
  always @(posedge amo_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //==============================
  // checks
  //==============================
  a_wr_data: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    mem_wr_vld |-> (((mem_wr_data ^ exp_data) & exp_mask) == '0))
  else
  begin
    value_err++;
    $display("ERR @%0t: mem_wr_data for id %0d is %h, expected %h", $time,
             $sampled(mem_wr_id), $sampled(mem_wr_data), $sampled(exp_data));
  end

  // index order and no extra pulses
  a_wr_order: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    mem_wr_vld |-> (rd_ptr < wr_ptr) && (mem_wr_id == exp_id))
  else
  begin
    order_err++;
    $display("ERR @%0t: mem_wr_id is %0d, expected %0d", $time,
             $sampled(mem_wr_id), $sampled(exp_id));
  end

  // uncontended req to mem write takes five cycles
  a_latency: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    (lat_mode && req_vld) |-> ##5 $rose(mem_wr_vld))
  else
  begin
    lat_err++;
    $display("latency check failed: no mem write five cycles after the request at %0t", $time);
  end

  a_stall_quiet: assert property (@(posedge amo_clk) disable iff (!cpurst_b)
    mem_stall |=> !mem_wr_vld)
  else
  begin
    stall_err++;
    $display("stall check failed: mem write seen while stalled at %0t", $time);
  end

  // pipe valids stay low from reset until the first request
  a_reset_quiet: assert property (@(posedge amo_clk)
    !req_seen |-> !mem_wr_vld && !u_dut.da_vld && !u_dut.amo_rst_vld)
  else
  begin
    reset_err++;
    $display("reset check failed: a valid rose before any request at %0t", $time);
  end

  //==============================
  // main sequence
  //==============================
  initial
  begin
    logic [1:0] sz;
    int         id_rr;
    seed        = 32'h4551;
    id_rr       = 0;
    alloc_vld   = 1'b0;
    alloc_id    = '0;
    alloc_data  = '0;
    req_vld     = 1'b0;
    req_func    = amo_pkg::OP_SWAP;
    req_size    = amo_pkg::SIZE_DWORD;
    req_ld_data = '0;
    req_id      = '0;
    mem_stall   = 1'b0;
    lat_mode    = 1'b0;
    req_seen    = 1'b0;

    // first edge falls inside reset
    @(posedge amo_clk);
    while (cpurst_b !== 1'b1)
    begin
      @(posedge amo_clk);
    end
    repeat (2) @(posedge amo_clk);

    // add and swap on every entry
    for (int i = 0; i < STB_DEPTH; i++)
    begin
      run_single(i, amo_pkg::OP_ADD, amo_pkg::SIZE_DWORD);
      run_single(i, amo_pkg::OP_SWAP, amo_pkg::SIZE_DWORD);
    end

    // logic ops
    for (int rep = 0; rep < 2; rep++)
    begin
      run_single((rep * 3) % STB_DEPTH, amo_pkg::OP_AND, amo_pkg::SIZE_DWORD);
      run_single((rep * 3 + 1) % STB_DEPTH, amo_pkg::OP_OR, amo_pkg::SIZE_DWORD);
      run_single((rep * 3 + 2) % STB_DEPTH, amo_pkg::OP_XOR, amo_pkg::SIZE_DWORD);
    end

    // signed and unsigned compares in both sizes
    for (int s = 0; s < 2; s++)
    begin
      sz = (s == 0) ? amo_pkg::SIZE_DWORD : amo_pkg::SIZE_WORD;
      for (int rep = 0; rep < 2; rep++)
      begin
        run_single(id_rr % STB_DEPTH, amo_pkg::OP_MAX, sz);
        run_single((id_rr + 1) % STB_DEPTH, amo_pkg::OP_MIN, sz);
        run_single((id_rr + 2) % STB_DEPTH, amo_pkg::OP_MAXU, sz);
        run_single((id_rr + 3) % STB_DEPTH, amo_pkg::OP_MINU, sz);
        id_rr = id_rr + 1;
      end
    end

    // word size compares the low half only
    run_single(0, amo_pkg::OP_ADD, amo_pkg::SIZE_WORD);
    run_single(1, amo_pkg::OP_SWAP, amo_pkg::SIZE_WORD);
    run_single(2, amo_pkg::OP_AND, amo_pkg::SIZE_WORD);
    run_single(3, amo_pkg::OP_OR, amo_pkg::SIZE_WORD);
    run_single(0, amo_pkg::OP_XOR, amo_pkg::SIZE_WORD);

    run_stall_drain();

    repeat (4) @(posedge amo_clk);
    if (rd_ptr != N_TRANS)
    begin
      drain_err++;
      $display("drain check failed: %0d of %0d memory writes seen", rd_ptr, N_TRANS);
    end

    print_counts();
    if (err_total() == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
verilog/amo_pkg.sv
verilog/amo_req_stage.sv
verilog/amo_alu.sv
verilog/amo_stb.sv
verilog/amo_lsu_top.sv
test/tb_clk_gen.sv
test/tb_amo_lsu.sv

// File: Bender.yml
package:
  name: amo_lsu

export_include_dirs:
  - include

sources:
  - verilog/amo_pkg.sv
  - verilog/amo_req_stage.sv
  - verilog/amo_alu.sv
  - verilog/amo_stb.sv
  - verilog/amo_lsu_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_amo_lsu.sv
